// File: logic/conv_weights.mem
// Filter 0 weights rise 1 to 25 across the window rows, bias 64
0001
0002
0003
0004
0005
0006
0007
0008
0009
000A
000B
000C
000D
000E
000F
0010
0011
0012
0013
0014
0015
0016
0017
0018
0019
0040
// Filter 1 has -2 on the top row, +3 on the bottom row, +1 at the centre, bias -1000
FFFE
FFFE
FFFE
FFFE
FFFE
0000
0000
0000
0000
0000
0000
0000
0001
0000
0000
0000
0000
0000
0000
0000
0003
0003
0003
0003
0003
FC18

// File: test/conv_cases.mem
// Pixel rows in hex, six per line, frame one then frame two
// Then one line per result in raster order, filter 0 then filter 1
02 07 0C 11 16 93
12 17 1C 21 26 2B
22 27 2C 31 18 3B
32 37 96 41 46 4B
42 47 4C 51 56 5B
E8 57 5C 61 66 6B
FF FF FF FF FF FF
FF FF FF FF FF FF
FF FF FF FF FF FF
FF FF FF FF FF FF
FF FF FF FF FF FF
FF FF FF FF FF FF
4D48 0040
55BD FF6E
6CBA 02BC
6689 00BE
7FFF 0212
7FFF 0212
7FFF 0212
7FFF 0212

// File: build.f
logic/conv_pkg.sv
logic/conv_line_buffer.sv
logic/conv_multiply.sv
logic/conv_adder_tree.sv
logic/conv_bias_output.sv
logic/conv_top.sv
test/conv_checker.sv
test/conv_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the convolution testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -Wno-fatal --top-module conv_tb -f build.f \
    && sim_out="$(./obj_dir/Vconv_tb)" \
    && printf '%s\n' "$sim_out" \
    && grep -q "Everything OK" <<< "$sim_out" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: test/conv_tb.sv
`timescale 1ns/1ps
`default_nettype none

module conv_tb
    import conv_pkg::*;
#(
    parameter int FRAME_W     = 6,
    parameter int FRAME_H     = 6,
    parameter int NUM_FILTERS = 2
);

    localparam int FRAMES     = 2;
    localparam int OUTS       = (FRAME_W - WIN + 1) * (FRAME_H - WIN + 1);
    localparam int NUM_PIXELS = FRAMES * FRAME_W * FRAME_H;
    localparam int CASE_WORDS = NUM_PIXELS + FRAMES * OUTS * NUM_FILTERS;
    localparam int CLK_NS     = 40;
    // Four cycles per pixel at the longest gap, plus reset and pipeline margin
    localparam int TIMEOUT_NS = (NUM_PIXELS * 4 + 100) * CLK_NS;

    logic                       clk;
    logic                       rst;
    logic                       pixel_valid;
    logic        [PIXEL_W-1:0]  pixel;
    logic                       result_valid;
    logic signed [RESULT_W-1:0] results [NUM_FILTERS];
    // Pixels of both frames, then the expected results
    logic        [15:0]         cases   [CASE_WORDS];
    logic                       done;
    int                         fail_count;
    int                         result_count;

    always #(CLK_NS / 2) clk = ~clk;

    conv_top #(
        .FRAME_W     (FRAME_W),
        .FRAME_H     (FRAME_H),
        .NUM_FILTERS (NUM_FILTERS)
    ) DUT (
        .i_clk          (clk),
        .i_rst          (rst),
        .i_pixel_valid  (pixel_valid),
        .i_pixel        (pixel),
        .o_result_valid (result_valid),
        .o_results      (results)
    );

    conv_checker #(
        .FRAME_W     (FRAME_W),
        .FRAME_H     (FRAME_H),
        .NUM_FILTERS (NUM_FILTERS),
        .FRAMES      (FRAMES),
        .CASE_WORDS  (CASE_WORDS)
    ) u_checker (
        .i_clk          (clk),
        .i_rst          (rst),
        .i_pixel_valid  (pixel_valid),
        .i_result_valid (result_valid),
        .i_results      (results),
        .i_cases        (cases),
        .o_done         (done),
        .o_fail_count   (fail_count),
        .o_result_count (result_count)
    );

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        int gap;
        clk         = 1'b0;
        rst         = 1'b1;
        pixel_valid = 1'b0;
        pixel       = '0;
        void'($urandom(32'hf92b));
        $readmemh("test/conv_cases.mem", cases);

        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // Zero to three idle cycles ahead of every pixel
        for (int p = 0; p < NUM_PIXELS; p++) begin
            gap = $urandom % 4;
            repeat (gap) begin
                @(posedge clk);
                pixel_valid <= 1'b0;
            end
            @(posedge clk);
            pixel_valid <= 1'b1;
            pixel       <= cases[p][PIXEL_W-1:0];
        end
        @(posedge clk);
        pixel_valid <= 1'b0;

        wait (done);
        @(posedge clk);
        if (fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    ////////////////////
    // Watchdog
    ////////////////////

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: run stopped after %0d ns with %0d of %0d results, results are missing",
                 TIMEOUT_NS, result_count, FRAMES * OUTS);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/conv_checker.sv
`timescale 1ns/1ps
`default_nettype none

module conv_checker
    import conv_pkg::*;
#(
    parameter int FRAME_W     = 6,
    parameter int FRAME_H     = 6,
    parameter int NUM_FILTERS = 2,
    parameter int FRAMES      = 2,
    parameter int CASE_WORDS  = 88
) (
    input  wire logic                       i_clk,
    input  wire logic                       i_rst,
    input  wire logic                       i_pixel_valid,
    input  wire logic                       i_result_valid,
    input  wire logic signed [RESULT_W-1:0] i_results [NUM_FILTERS],
    input  wire logic        [15:0]         i_cases   [CASE_WORDS],
    output logic                            o_done,
    output int                              o_fail_count,
    output int                              o_result_count
);

    localparam int OUTS        = (FRAME_W - WIN + 1) * (FRAME_H - WIN + 1);
    localparam int NUM_PIXELS  = FRAMES * FRAME_W * FRAME_H;
    localparam int NUM_RESULTS = FRAMES * OUTS;

    // Own frame position that only accepted pixels move
    int   col;
    int   row;
    // In-frame windows accepted so far that each owe a result
    int   windows;
    int   frame_errors;
    int   tests_passed;
    int   tests_failed;
    logic rst_q;
    logic reset_quiet;

    initial begin
        col            = 0;
        row            = 0;
        windows        = 0;
        frame_errors   = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        rst_q          = 1'b1;
        reset_quiet    = 1'b1;
        o_done         = 1'b0;
        o_result_count = 0;
    end

    assign o_fail_count = tests_failed;

    task automatic report_test(input string name, input bit ok);
        if (ok) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail", name);
        end
    endtask

    ////////////////////
    // Result compare
    ////////////////////

    // Results come back in raster order, so the count indexes the case file
    task automatic check_result();
        int                  base;
        logic [RESULT_W-1:0] expected;
        if (o_result_count >= windows) begin
            $display("extra result: valid went high with no in-frame window accepted for it");
            frame_errors++;
        end else begin
            base = NUM_PIXELS + o_result_count * NUM_FILTERS;
            for (int f = 0; f < NUM_FILTERS; f++) begin
                expected = i_cases[base+f];
                if (i_results[f] !== expected) begin
                    $display("error: o_results[%0d] of result %0d is %h, expected %h",
                             f, o_result_count, i_results[f], expected);
                    frame_errors++;
                end
            end
            o_result_count++;
            // Frame done once all its windows are back
            if (o_result_count % OUTS == 0) begin
                report_test($sformatf("frame %0d", o_result_count / OUTS), frame_errors == 0);
                frame_errors = 0;
            end
            if (o_result_count == NUM_RESULTS) begin
                $display("results %0d of %0d, tests passed %0d, tests failed %0d",
                         o_result_count, NUM_RESULTS, tests_passed, tests_failed);
                o_done = 1'b1;
            end
        end
    endtask

    always @(posedge i_clk) begin
        if (i_rst) begin
            if (i_result_valid) begin
                $display("reset: result valid went high while reset was asserted");
                reset_quiet = 1'b0;
            end
        end else begin
            if (rst_q) begin
                report_test("reset", reset_quiet);
            end
            // Compare before counting this edge's pixel
            if (i_result_valid) begin
                check_result();
            end
            if (i_pixel_valid) begin
                if (col >= WIN - 1 && row >= WIN - 1) begin
                    windows++;
                end
                if (col == FRAME_W - 1) begin
                    col = 0;
                    row = (row == FRAME_H - 1) ? 0 : row + 1;
                end else begin
                    col++;
                end
            end
        end
        rst_q = i_rst;
    end

endmodule

`default_nettype wire

// File: logic/conv_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv_top
    import conv_pkg::*;
#(
    parameter int FRAME_W     = 6,
    parameter int FRAME_H     = 6,
    parameter int NUM_FILTERS = 2
) (
    input  wire logic                       i_clk,
    input  wire logic                       i_rst,
    input  wire logic                       i_pixel_valid,
    input  wire logic         [PIXEL_W-1:0] i_pixel,
    output logic                            o_result_valid,
    output logic signed      [RESULT_W-1:0] o_results [NUM_FILTERS]
);

    //////////////////////
    // Stage links
    //////////////////////

    logic                       window_valid;
    logic        [PIXEL_W-1:0]  window   [TAPS];

    logic                       prod_valid;
    logic signed [PROD_W-1:0]   products [NUM_FILTERS][TAPS];

    logic                       sum_valid;
    logic signed [SUM_W-1:0]    sums     [NUM_FILTERS];

    // Window valid one cycle after the accepting edge
    conv_line_buffer #(
        .FRAME_W (FRAME_W),
        .FRAME_H (FRAME_H)
    ) u_line_buffer (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_pixel_valid  (i_pixel_valid),
        .i_pixel        (i_pixel),
        .o_window_valid (window_valid),
        .o_window       (window)
    );

    conv_multiply #(.NUM_FILTERS(NUM_FILTERS)) u_multiply (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_window_valid (window_valid),
        .i_window       (window),
        .o_prod_valid   (prod_valid),
        .o_products     (products)
    );

    // Five registered levels
    conv_adder_tree #(.NUM_FILTERS(NUM_FILTERS)) u_adder_tree (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_prod_valid (prod_valid),
        .i_products   (products),
        .o_sum_valid  (sum_valid),
        .o_sums       (sums)
    );

    conv_bias_output #(.NUM_FILTERS(NUM_FILTERS)) u_bias_output (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_sum_valid    (sum_valid),
        .i_sums         (sums),
        .o_result_valid (o_result_valid),
        .o_results      (o_results)
    );

endmodule

`default_nettype wire

// File: logic/conv_bias_output.sv
`timescale 1ns/1ps
`default_nettype none

module conv_bias_output
    import conv_pkg::*;
#(
    parameter int NUM_FILTERS = 2
) (
    input  wire logic                       i_clk,
    input  wire logic                       i_rst,
    input  wire logic                       i_sum_valid,
    input  wire logic signed    [SUM_W-1:0] i_sums    [NUM_FILTERS],
    output logic                            o_result_valid,
    output logic signed      [RESULT_W-1:0] o_results [NUM_FILTERS]
);

    // Same coefficient ROM as the multipliers with only the bias words used here
    logic        [BIAS_W-1:0] rom [NUM_FILTERS*ROM_STRIDE];
    logic signed [BIAS_W-1:0] bias   [NUM_FILTERS];
    // One extra bit so the bias add cannot wrap
    logic signed [SUM_W:0]    biased [NUM_FILTERS];

    initial begin
        $readmemh(WEIGHTS_FILE, rom);
    end

    always_comb begin
        for (int f = 0; f < NUM_FILTERS; f++) begin
            bias[f]   = rom[f*ROM_STRIDE+TAPS];
            biased[f] = (SUM_W + 1)'(i_sums[f]) + (SUM_W + 1)'(bias[f]);
        end
    end

    // Clamp into the signed 16-bit range
    always_ff @(posedge i_clk) begin
        for (int f = 0; f < NUM_FILTERS; f++) begin
            if (biased[f] > RESULT_MAX) begin
                o_results[f] <= RESULT_MAX;
            end else if (biased[f] < RESULT_MIN) begin
                o_results[f] <= RESULT_MIN;
            end else begin
                o_results[f] <= RESULT_W'(biased[f]);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_result_valid <= 1'b0;
        end else begin
            o_result_valid <= i_sum_valid;
        end
    end

endmodule

`default_nettype wire

// File: logic/conv_adder_tree.sv
`timescale 1ns/1ps
`default_nettype none

module conv_adder_tree
    import conv_pkg::*;
#(
    parameter int NUM_FILTERS = 2
) (
    input  wire logic                     i_clk,
    input  wire logic                     i_rst,
    input  wire logic                     i_prod_valid,
    input  wire logic signed [PROD_W-1:0] i_products [NUM_FILTERS][TAPS],
    output logic                          o_sum_valid,
    output logic signed       [SUM_W-1:0] o_sums     [NUM_FILTERS]
);

    // Products widened to the full sum width
    logic signed [SUM_W-1:0] ext [NUM_FILTERS][TAPS];

    // Registered partial sums where level s holds node_count(s+1) entries
    logic signed [SUM_W-1:0] node [TREE_STAGES][NUM_FILTERS][TAPS];

    // Valid follows the data through every level
    logic [TREE_STAGES-1:0] valid_sr;

    // Entry count at level s runs 25, 13, 7, 4, 2 and 1
    function automatic int node_count(input int s);
        return (TAPS + (1 << s) - 1) >> s;
    endfunction

    // Operand k feeding level s
    function automatic logic signed [SUM_W-1:0] stage_in(input int s, input int f, input int k);
        return (s == 0) ? ext[f][k] : node[s-1][f][k];
    endfunction

    always_comb begin
        for (int f = 0; f < NUM_FILTERS; f++) begin
            for (int t = 0; t < TAPS; t++) begin
                ext[f][t] = SUM_W'(i_products[f][t]);
            end
        end
    end

    //////////////////////
    // Pairwise levels
    //////////////////////

    always_ff @(posedge i_clk) begin
        for (int s = 0; s < TREE_STAGES; s++) begin
            for (int f = 0; f < NUM_FILTERS; f++) begin
                for (int j = 0; j < node_count(s + 1); j++) begin
                    if (2 * j + 1 < node_count(s)) begin
                        node[s][f][j] <= stage_in(s, f, 2 * j) + stage_in(s, f, 2 * j + 1);
                    end else begin
                        // Odd leftover passes to the next level unchanged
                        node[s][f][j] <= stage_in(s, f, 2 * j);
                    end
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[TREE_STAGES-2:0], i_prod_valid};
        end
    end

    // Last level has a single entry per filter
    always_comb begin
        for (int f = 0; f < NUM_FILTERS; f++) begin
            o_sums[f] = node[TREE_STAGES-1][f][0];
        end
    end

    assign o_sum_valid = valid_sr[TREE_STAGES-1];

endmodule

`default_nettype wire

// File: logic/conv_multiply.sv
`timescale 1ns/1ps
`default_nettype none

module conv_multiply
    import conv_pkg::*;
#(
    parameter int NUM_FILTERS = 2
) (
    input  wire logic                      i_clk,
    input  wire logic                      i_rst,
    input  wire logic                      i_window_valid,
    input  wire logic        [PIXEL_W-1:0] i_window   [TAPS],
    output logic                           o_prod_valid,
    output logic signed       [PROD_W-1:0] o_products [NUM_FILTERS][TAPS]
);

    // Coefficient ROM whose bias entries only the output stage reads
    logic [BIAS_W-1:0] rom [NUM_FILTERS*ROM_STRIDE];

    // Weights per filter in window row order
    logic signed [WEIGHT_W-1:0] weight [NUM_FILTERS][TAPS];

    initial begin
        $readmemh(WEIGHTS_FILE, rom);
    end

    // Weight sits in the low bits of its ROM word
    always_comb begin
        for (int f = 0; f < NUM_FILTERS; f++) begin
            for (int t = 0; t < TAPS; t++) begin
                weight[f][t] = rom[f*ROM_STRIDE+t][WEIGHT_W-1:0];
            end
        end
    end

    // One multiplier per filter and tap
    // Pixel gets a zero sign bit so the product stays signed
    always_ff @(posedge i_clk) begin
        for (int f = 0; f < NUM_FILTERS; f++) begin
            for (int t = 0; t < TAPS; t++) begin
                o_products[f][t] <= weight[f][t] * $signed({1'b0, i_window[t]});
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_prod_valid <= 1'b0;
        end else begin
            o_prod_valid <= i_window_valid;
        end
    end

endmodule

`default_nettype wire

// File: logic/conv_line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module conv_line_buffer
    import conv_pkg::*;
#(
    parameter int FRAME_W = 6,
    parameter int FRAME_H = 6
) (
    input  wire logic               i_clk,
    input  wire logic               i_rst,
    input  wire logic               i_pixel_valid,
    input  wire logic [PIXEL_W-1:0] i_pixel,
    output logic                    o_window_valid,
    output logic      [PIXEL_W-1:0] o_window [TAPS]
);

    localparam int COL_W = $clog2(FRAME_W);
    localparam int ROW_W = $clog2(FRAME_H);

    // Accepted pixel waits here and enters the window on the following edge
    logic               pix_valid_q;
    logic [PIXEL_W-1:0] pix_q;

    // Four previous rows
    // Last entry of each holds the same column one row further up
    logic [PIXEL_W-1:0] row_mem [WIN-1][FRAME_W];

    // Column entering the window with the top row first
    logic [PIXEL_W-1:0] new_col [WIN];

    // Frame position of the pixel held in pix_q
    logic [COL_W-1:0] col;
    logic [ROW_W-1:0] row;
    logic             in_frame;

    //////////////////////
    // Input register
    //////////////////////

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pix_valid_q <= 1'b0;
        end else begin
            pix_valid_q <= i_pixel_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_pixel_valid) begin
            pix_q <= i_pixel;
        end
    end

    //////////////////////
    // Row storage and window
    //////////////////////

    // Bottom window row takes the new pixel and the rows above come from the row memories
    always_comb begin
        new_col[WIN-1] = pix_q;
        for (int r = 0; r < WIN - 1; r++) begin
            new_col[r] = row_mem[WIN-2-r][FRAME_W-1];
        end
    end

    // Only accepted pixels move the memories and the window
    always_ff @(posedge i_clk) begin
        if (pix_valid_q) begin
            for (int k = 0; k < WIN - 1; k++) begin
                // Each row memory feeds the one above it
                row_mem[k][0] <= (k == 0) ? pix_q : row_mem[k-1][FRAME_W-1];
                for (int i = 1; i < FRAME_W; i++) begin
                    row_mem[k][i] <= row_mem[k][i-1];
                end
            end
            // Window moves one column left and takes the new column on the right
            for (int r = 0; r < WIN; r++) begin
                for (int c = 0; c < WIN - 1; c++) begin
                    o_window[r*WIN+c] <= o_window[r*WIN+c+1];
                end
                o_window[r*WIN+WIN-1] <= new_col[r];
            end
        end
    end

    //////////////////////
    // Frame position
    //////////////////////

    // Window lies fully inside the frame once four rows and columns are behind it
    assign in_frame = (col >= COL_W'(WIN - 1)) && (row >= ROW_W'(WIN - 1));

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            col            <= '0;
            row            <= '0;
            o_window_valid <= 1'b0;
        end else begin
            o_window_valid <= pix_valid_q && in_frame;
            if (pix_valid_q) begin
                if (col == COL_W'(FRAME_W - 1)) begin
                    col <= '0;
                    // Wrap at frame end so the next frame follows directly
                    row <= (row == ROW_W'(FRAME_H - 1)) ? '0 : row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/conv_pkg.sv
`default_nettype none

package conv_pkg;

    //////////////////////
    // Data widths
    //////////////////////

    // Unsigned grey-scale pixel
    localparam int PIXEL_W  = 8;
    // Signed filter weight
    localparam int WEIGHT_W = 8;
    // Signed weight times zero-extended pixel
    localparam int PROD_W   = WEIGHT_W + PIXEL_W + 1;

    // Window geometry
    localparam int WIN  = 5;
    localparam int TAPS = WIN * WIN;

    // Five pairwise levels reduce 25 products with one bit of growth per level
    localparam int TREE_STAGES = $clog2(TAPS);
    localparam int SUM_W       = PROD_W + TREE_STAGES;

    localparam int BIAS_W   = 16;
    localparam int RESULT_W = 16;

    // Saturation bounds of the signed result
    localparam logic signed [RESULT_W-1:0] RESULT_MAX = {1'b0, {(RESULT_W-1){1'b1}}};
    localparam logic signed [RESULT_W-1:0] RESULT_MIN = {1'b1, {(RESULT_W-1){1'b0}}};

    //////////////////////
    // Coefficient ROM
    //////////////////////

    // Each filter takes 25 weights in row order followed by its bias
    localparam int    ROM_STRIDE   = TAPS + 1;
    localparam string WEIGHTS_FILE = "logic/conv_weights.mem";

endpackage

`default_nettype wire
